// File: bench/exec_mem_assert.sv
`default_nettype none

module exec_mem_assert import pipe_pkg::*; (
   input logic CLK,
   input logic nRST,
   input logic stall,
   input logic halted,
   input logic mem_stall,
   input wb_t  wb
);
   timeunit 1ns;
   timeprecision 100ps;

   // every stage is cleared while reset is held, so nothing can interlock
   stall_in_reset: assert property (@(posedge CLK) !nRST |-> !stall)
      else $error("stall high while reset is asserted");

   no_wb_after_halt: assert property (@(posedge CLK) disable iff (!nRST) halted |-> !wb.wen)
      else $error("writeback enable high while halted");

   // a miss holds the pipeline for the penalty and then dhit lets the latch move on
   miss_penalty: assert property (@(posedge CLK) disable iff (!nRST)
                                  $rose(mem_stall) |-> ##MISS_CYCLES !mem_stall)
      else $error("mem_stall did not end after the miss penalty");

endmodule

`default_nettype wire

// File: bench/exec_mem_tb.sv
`default_nettype none

module exec_mem_tb import cpu_types_pkg::*, pipe_pkg::*;;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 4;
   localparam int N_DIRECTED   = 7;
   localparam int N_RANDOM     = 150;
   localparam int LIMIT_CYCLES = (N_DIRECTED + N_RANDOM + 1) * (MISS_CYCLES + 4) + 8 + 200;

   logic   CLK;
   logic   nRST;
   instr_t instr;
   logic   instr_valid;
   logic   stall;
   wb_t    wb;
   logic   halted;

   logic [15:0] lfsr;
   word_t       model_regs [32];
   word_t       model_mem [DMEM_WORDS];
   instr_t      prog [$];
   wb_t         exp_q [$];
   int          n_expected;
   int          wb_pulses;
   int          value_errs;
   int          other_errs;

   exec_mem_top uut (
      .CLK         (CLK),
      .nRST        (nRST),
      .instr       (instr),
      .instr_valid (instr_valid),
      .stall       (stall),
      .wb          (wb),
      .halted      (halted)
   );

   bind exec_mem_top exec_mem_assert u_assert (
      .CLK       (CLK),
      .nRST      (nRST),
      .stall     (stall),
      .halted    (halted),
      .mem_stall (mem_stall),
      .wb        (wb)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // the LFSR steps once per bit taken and gives out its low bit first
   function automatic logic [15:0] take_bits(int n);
      logic [15:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[14:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
      return v;
   endfunction

   function automatic regbits_t pick_reg();
      return regbits_t'(take_bits(3) % 16'd7 + 16'd1);
   endfunction

   function automatic instr_t make_r(funct_t f, regbits_t s, regbits_t t, regbits_t d);
      instr_t w;
      w.r = '{opcode: RTYPE, rs: s, rt: t, rd: d, shamt: 5'd0, funct: f};
      return w;
   endfunction

   function automatic instr_t make_i(opcode_t op, regbits_t s, regbits_t t, logic [15:0] imm);
      instr_t w;
      w.i = '{opcode: op, rs: s, rt: t, imm16: imm};
      return w;
   endfunction

   // the ISA model updates the model state and queues the expected writeback
   function automatic void ref_exec(instr_t w);
      word_t                 a;
      word_t                 b;
      word_t                 sext;
      word_t                 res;
      logic [DMEM_ABITS-1:0] widx;
      logic                  wr;
      regbits_t              d;
      a    = model_regs[w.i.rs];
      b    = model_regs[w.i.rt];
      sext = {{16{w.i.imm16[15]}}, w.i.imm16};
      widx = DMEM_ABITS'((a + sext) >> 2);
      res  = '0;
      wr   = 1'b1;
      d    = w.i.rt;
      case (w.i.opcode)
         RTYPE: begin
            d = w.r.rd;
            case (w.r.funct)
               ADDU:    res = a + b;
               SUBU:    res = a - b;
               AND:     res = a & b;
               OR:      res = a | b;
               XOR:     res = a ^ b;
               SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: wr = 1'b0;
            endcase
         end
         ADDIU: res = a + sext;
         ORI:   res = a | {16'h0000, w.i.imm16};
         LUI:   res = {w.i.imm16, 16'h0000};
         LW:    res = model_mem[widx];
         SW: begin
            model_mem[widx] = b;
            wr = 1'b0;
         end
         default: wr = 1'b0;
      endcase
      if (wr && d != '0) begin
         model_regs[d] = res;
         exp_q.push_back(wb_t'{wen: 1'b1, wsel: d, data: res});
      end
   endfunction

   function automatic void add_instr(instr_t w);
      prog.push_back(w);
      ref_exec(w);
   endfunction

   // loads and stores use r0 as base so the address is always a legal word
   function automatic instr_t random_instr();
      int          kind;
      regbits_t    a;
      regbits_t    b;
      regbits_t    c;
      logic [15:0] addr;
      instr_t      w;
      kind = int'(take_bits(4)) % 11;
      a    = pick_reg();
      b    = pick_reg();
      c    = pick_reg();
      addr = take_bits(DMEM_ABITS) << 2;
      case (kind)
         0:       w = make_r(ADDU, a, b, c);
         1:       w = make_r(SUBU, a, b, c);
         2:       w = make_r(AND, a, b, c);
         3:       w = make_r(OR, a, b, c);
         4:       w = make_r(XOR, a, b, c);
         5:       w = make_r(SLT, a, b, c);
         6:       w = make_i(ADDIU, a, b, take_bits(16));
         7:       w = make_i(ORI, a, b, take_bits(16));
         8:       w = make_i(LUI, a, b, take_bits(16));
         9:       w = make_i(LW, 5'd0, b, addr);
         default: w = make_i(SW, 5'd0, b, addr);
      endcase
      return w;
   endfunction

   // a dependent chain, a store then a hit, then a miss on a word never written
   function automatic void build_program();
      add_instr(make_i(LUI, 5'd0, 5'd1, 16'h1234));
      add_instr(make_i(ORI, 5'd1, 5'd1, 16'h5678));
      add_instr(make_r(ADDU, 5'd1, 5'd1, 5'd2));
      add_instr(make_i(SW, 5'd0, 5'd2, 16'h0010));
      add_instr(make_i(LW, 5'd0, 5'd3, 16'h0010));
      add_instr(make_i(LW, 5'd0, 5'd4, 16'h00F0));
      add_instr(make_r(SUBU, 5'd3, 5'd4, 5'd5));
      for (int k = 0; k < N_RANDOM; k++) begin
         add_instr(random_instr());
      end
      add_instr(make_i(HALT, 5'd0, 5'd0, 16'h0000));
   endfunction

   always @(negedge CLK) begin
      wb_t e;
      if (nRST && wb.wen) begin
         wb_pulses++;
         assert (!halted) else begin
            other_errs++;
            $display("writeback to r%0d seen after halted went high", wb.wsel);
         end
         assert (exp_q.size() != 0) else begin
            other_errs++;
            $display("writeback to r%0d that the program does not produce", wb.wsel);
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            assert (wb.wsel == e.wsel && wb.data == e.data) else begin
               value_errs++;
               $display("Fail %0t: expected r%0d = %h, got r%0d = %h",
                        $time, e.wsel, e.data, wb.wsel, wb.data);
            end
         end
      end
   end

   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("timeout: the pipeline did not halt within %0d cycles", LIMIT_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      int idx;
      CLK         = 1'b0;
      nRST        = 1'b0;
      instr       = '0;
      instr_valid = 1'b0;
      lfsr        = 16'd54;
      wb_pulses   = 0;
      value_errs  = 0;
      other_errs  = 0;
      for (int k = 0; k < 32; k++) begin
         model_regs[k] = '0;
      end
      for (int k = 0; k < DMEM_WORDS; k++) begin
         model_mem[k] = '0;
      end
      build_program();
      n_expected = exp_q.size();
      repeat (8) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;
      idx  = 0;
      // stall is settled a nanosecond after the falling edge
      while (idx < prog.size()) begin
         @(negedge CLK);
         instr       = prog[idx];
         instr_valid = 1'b1;
         #1;
         if (!stall) begin
            idx++;
         end
      end
      @(negedge CLK);
      instr_valid = 1'b0;
      wait (halted === 1'b1);
      @(negedge CLK);
      assert (exp_q.size() == 0) else begin
         other_errs++;
         $display("halted rose with %0d writebacks still missing", exp_q.size());
      end
      assert (stall) else begin
         other_errs++;
         $display("stall was low after halted went high");
      end
      repeat (10) @(negedge CLK);
      assert (wb_pulses == n_expected) else begin
         other_errs++;
         $display("saw %0d writebacks where %0d were expected", wb_pulses, n_expected);
      end
      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      if (value_errs + other_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
verilog/cpu_types_pkg.sv
verilog/pipe_pkg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/ex_mem_latch.sv
verilog/memory_stage.sv
verilog/exec_mem_top.sv
bench/exec_mem_assert.sv
bench/exec_mem_tb.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module exec_mem_tb \
   -f list.f -o sim_exec_mem
./obj_dir/sim_exec_mem | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
   echo "simulation reported failure, see sim.log"
   exit 1
fi
echo "simulation finished without failure"

// File: verilog/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regbits_t;

   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      ADDIU = 6'h09,
      ORI   = 6'h0D,
      LUI   = 6'h0F,
      LW    = 6'h23,
      SW    = 6'h2B,
      HALT  = 6'h3F
   } opcode_t;

   typedef enum logic [5:0] {
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      XOR  = 6'h26,
      SLT  = 6'h2A
   } funct_t;

   typedef struct packed {
      opcode_t    opcode;
      regbits_t   rs;
      regbits_t   rt;
      regbits_t   rd;
      logic [4:0] shamt;
      funct_t     funct;
   } r_type_t;

   typedef struct packed {
      opcode_t     opcode;
      regbits_t    rs;
      regbits_t    rt;
      logic [15:0] imm16;
   } i_type_t;

   // one issued word, viewed through whichever format its opcode selects
   typedef union packed {
      r_type_t r;
      i_type_t i;
   } instr_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASSB
   } alu_op_t;

endpackage

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage import cpu_types_pkg::*, pipe_pkg::*; (
   input  logic    CLK,
   input  logic    nRST,
   input  instr_t  instr,
   input  logic    instr_valid,
   input  logic    mem_stall,
   input  logic    halted,
   input  wb_t     wb,
   output logic    stall,
   output dec_ex_t dec_ex
);

   word_t      regs [32];
   word_t      rdat1;
   word_t      rdat2;
   logic       reads_rs;
   logic       reads_rt;
   logic       hit_rs;
   logic       hit_rt;
   logic       latch_clear;
   logic       accept;
   logic       halt_pend;
   logic [1:0] rec_valid;
   regbits_t   rec_dest [2];
   dec_ex_t    dec_nxt;

   function automatic logic match(logic v, regbits_t d, regbits_t src);
      return v && (d == src);
   endfunction

   // a writeback on the bus this cycle is passed straight to the read
   assign rdat1 = (instr.i.rs == '0) ? '0 :
                  (wb.wen && wb.wsel == instr.i.rs) ? wb.data : regs[instr.i.rs];
   assign rdat2 = (instr.i.rt == '0) ? '0 :
                  (wb.wen && wb.wsel == instr.i.rt) ? wb.data : regs[instr.i.rt];

   always_comb begin
      reads_rs = 1'b0;
      reads_rt = 1'b0;
      case (instr.i.opcode)
         RTYPE, SW: begin
            reads_rs = 1'b1;
            reads_rt = 1'b1;
         end
         ADDIU, ORI, LW: reads_rs = 1'b1;
         default: ;
      endcase
   end

   // rec slot 0 mirrors execute and slot 1 the EX/MEM latch
   assign latch_clear = wb.wen && (wb.wsel == rec_dest[1]);
   assign hit_rs = match(dec_ex.valid && dec_ex.regwrite, dec_ex.dest, instr.i.rs)
                || match(rec_valid[0], rec_dest[0], instr.i.rs)
                || match(rec_valid[1] && !latch_clear, rec_dest[1], instr.i.rs);
   assign hit_rt = match(dec_ex.valid && dec_ex.regwrite, dec_ex.dest, instr.i.rt)
                || match(rec_valid[0], rec_dest[0], instr.i.rt)
                || match(rec_valid[1] && !latch_clear, rec_dest[1], instr.i.rt);

   assign stall  = (reads_rs && hit_rs) || (reads_rt && hit_rt) || mem_stall
                || halt_pend || halted;
   assign accept = instr_valid && !stall;

   always_comb begin
      dec_nxt          = '0;
      dec_nxt.valid    = 1'b1;
      dec_nxt.rdat1    = rdat1;
      dec_nxt.rdat2    = rdat2;
      dec_nxt.imm16    = instr.i.imm16;
      dec_nxt.dest     = instr.i.rt;
      dec_nxt.imm_kind = IMM_SIGN;
      case (instr.i.opcode)
         RTYPE: begin
            dec_nxt.imm_kind = IMM_NONE;
            dec_nxt.dest     = instr.r.rd;
            dec_nxt.regwrite = 1'b1;
            case (instr.r.funct)
               ADDU:    dec_nxt.alu_op = ALU_ADD;
               SUBU:    dec_nxt.alu_op = ALU_SUB;
               AND:     dec_nxt.alu_op = ALU_AND;
               OR:      dec_nxt.alu_op = ALU_OR;
               XOR:     dec_nxt.alu_op = ALU_XOR;
               SLT:     dec_nxt.alu_op = ALU_SLT;
               default: dec_nxt.regwrite = 1'b0;
            endcase
         end
         ADDIU: begin
            dec_nxt.alu_op   = ALU_ADD;
            dec_nxt.regwrite = 1'b1;
         end
         ORI: begin
            dec_nxt.alu_op   = ALU_OR;
            dec_nxt.imm_kind = IMM_ZERO;
            dec_nxt.regwrite = 1'b1;
         end
         LUI: begin
            dec_nxt.alu_op   = ALU_PASSB;
            dec_nxt.imm_kind = IMM_UPPER;
            dec_nxt.regwrite = 1'b1;
         end
         LW: begin
            dec_nxt.alu_op   = ALU_ADD;
            dec_nxt.regwrite = 1'b1;
            dec_nxt.dmemREN  = 1'b1;
         end
         SW: begin
            dec_nxt.alu_op  = ALU_ADD;
            dec_nxt.dmemWEN = 1'b1;
         end
         HALT:    dec_nxt.halt = 1'b1;
         default: ;
      endcase
      // writes to register 0 are dropped here so nothing downstream tracks them
      if (dec_nxt.dest == '0) begin
         dec_nxt.regwrite = 1'b0;
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         dec_ex    <= '0;
         rec_valid <= '0;
      end else if (!mem_stall) begin
         dec_ex    <= accept ? dec_nxt : '0;
         rec_valid <= {rec_valid[0], dec_ex.valid && dec_ex.regwrite};
      end
   end

   always_ff @(posedge CLK) begin
      if (!mem_stall) begin
         rec_dest[0] <= dec_ex.dest;
         rec_dest[1] <= rec_dest[0];
      end
   end

   // once a HALT is taken nothing more enters, until halted takes over
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         halt_pend <= 1'b0;
      end else if (halted) begin
         halt_pend <= 1'b0;
      end else if (accept && instr.i.opcode == HALT) begin
         halt_pend <= 1'b1;
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wen) begin
         regs[wb.wsel] <= wb.data;
      end
   end

endmodule

`default_nettype wire

// File: verilog/ex_mem_latch.sv
`default_nettype none

module ex_mem_latch import pipe_pkg::*; (
   input  logic    CLK,
   input  logic    nRST,
   input  ex_mem_t ex_in,
   input  logic    dhit,
   output ex_mem_t ex_mem,
   output logic    mem_stall
);

   logic pending;

   // a data access sits here until the memory stage answers with dhit
   assign pending   = ex_mem.valid && (ex_mem.dmemREN || ex_mem.dmemWEN);
   assign mem_stall = pending && !dhit;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         ex_mem <= '0;
      end else if (!mem_stall) begin
         ex_mem <= ex_in;
      end
   end

endmodule

`default_nettype wire

// File: verilog/exec_mem_top.sv
`default_nettype none

module exec_mem_top import cpu_types_pkg::*, pipe_pkg::*; (
   input  logic   CLK,
   input  logic   nRST,
   input  instr_t instr,
   input  logic   instr_valid,
   output logic   stall,
   output wb_t    wb,
   output logic   halted
);

   dec_ex_t dec_ex;
   ex_mem_t ex_out;
   ex_mem_t ex_mem;
   logic    mem_stall;
   logic    dhit;

   decode_stage u_decode (
      .CLK         (CLK),
      .nRST        (nRST),
      .instr       (instr),
      .instr_valid (instr_valid),
      .mem_stall   (mem_stall),
      .halted      (halted),
      .wb          (wb),
      .stall       (stall),
      .dec_ex      (dec_ex)
   );

   execute_stage u_execute (
      .CLK       (CLK),
      .nRST      (nRST),
      .dec_ex    (dec_ex),
      .mem_stall (mem_stall),
      .ex_out    (ex_out)
   );

   ex_mem_latch u_latch (
      .CLK       (CLK),
      .nRST      (nRST),
      .ex_in     (ex_out),
      .dhit      (dhit),
      .ex_mem    (ex_mem),
      .mem_stall (mem_stall)
   );

   memory_stage u_memory (
      .CLK    (CLK),
      .nRST   (nRST),
      .ex_mem (ex_mem),
      .dhit   (dhit),
      .wb     (wb),
      .halted (halted)
   );

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`default_nettype none

module execute_stage import cpu_types_pkg::*, pipe_pkg::*; (
   input  logic    CLK,
   input  logic    nRST,
   input  dec_ex_t dec_ex,
   input  logic    mem_stall,
   output ex_mem_t ex_out
);

   word_t opb;
   word_t result;

   always_comb begin
      case (dec_ex.imm_kind)
         IMM_SIGN:  opb = {{16{dec_ex.imm16[15]}}, dec_ex.imm16};
         IMM_ZERO:  opb = {16'h0000, dec_ex.imm16};
         IMM_UPPER: opb = {dec_ex.imm16, 16'h0000};
         default:   opb = dec_ex.rdat2;
      endcase
   end

   always_comb begin
      case (dec_ex.alu_op)
         ALU_ADD: result = dec_ex.rdat1 + opb;
         ALU_SUB: result = dec_ex.rdat1 - opb;
         ALU_AND: result = dec_ex.rdat1 & opb;
         ALU_OR:  result = dec_ex.rdat1 | opb;
         ALU_XOR: result = dec_ex.rdat1 ^ opb;
         ALU_SLT: result = {31'd0, $signed(dec_ex.rdat1) < $signed(opb)};
         // LUI only passes the shifted immediate
         default: result = opb;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         ex_out <= '0;
      end else if (!mem_stall) begin
         ex_out <= '{
            valid:     dec_ex.valid,
            aluResult: result,
            rdat2:     dec_ex.rdat2,
            dest:      dec_ex.dest,
            regwrite:  dec_ex.regwrite,
            dmemREN:   dec_ex.dmemREN,
            dmemWEN:   dec_ex.dmemWEN,
            halt:      dec_ex.halt
         };
      end
   end

endmodule

`default_nettype wire

// File: verilog/memory_stage.sv
`default_nettype none

module memory_stage import cpu_types_pkg::*, pipe_pkg::*; (
   input  logic    CLK,
   input  logic    nRST,
   input  ex_mem_t ex_mem,
   output logic    dhit,
   output wb_t     wb,
   output logic    halted
);

   word_t                 dmem [DMEM_WORDS];
   logic [DMEM_ABITS-1:0] widx;
   logic [LINE_TAG_W-1:0] line_tag;
   logic                  line_valid;
   logic [MISS_CNT_W-1:0] miss_cnt;
   logic                  access;
   logic                  line_hit;
   logic                  fill_done;

   // byte address in, so the low two bits are dropped
   assign widx      = ex_mem.aluResult[DMEM_ABITS+1:2];
   assign access    = ex_mem.valid && (ex_mem.dmemREN || ex_mem.dmemWEN);
   assign line_hit  = line_valid && (line_tag == widx[DMEM_ABITS-1 -: LINE_TAG_W]);
   assign fill_done = (miss_cnt == MISS_CNT_W'(MISS_CYCLES));
   assign dhit      = access && (line_hit || fill_done);

   always_comb begin
      wb.wen  = ex_mem.valid && ex_mem.regwrite && (!ex_mem.dmemREN || dhit);
      wb.wsel = ex_mem.dest;
      wb.data = ex_mem.dmemREN ? dmem[widx] : ex_mem.aluResult;
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (dhit && ex_mem.dmemWEN) begin
         dmem[widx] <= ex_mem.rdat2;
      end
   end

   // a miss waits out the penalty, then the line becomes the buffered one
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         line_valid <= 1'b0;
         line_tag   <= '0;
         miss_cnt   <= '0;
      end else if (access && !line_hit) begin
         if (fill_done) begin
            line_valid <= 1'b1;
            line_tag   <= widx[DMEM_ABITS-1 -: LINE_TAG_W];
            miss_cnt   <= '0;
         end else begin
            miss_cnt <= miss_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         halted <= 1'b0;
      end else if (ex_mem.valid && ex_mem.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

   import cpu_types_pkg::*;

   localparam int DMEM_WORDS  = 64;
   localparam int DMEM_ABITS  = 6;
   localparam int LINE_WORDS  = 4;
   localparam int MISS_CYCLES = 3;

   // the hit buffer tags a line by the word index without its offset bits
   localparam int LINE_TAG_W = DMEM_ABITS - $clog2(LINE_WORDS);
   localparam int MISS_CNT_W = $clog2(MISS_CYCLES + 1);

   // how execute forms its second operand
   typedef enum logic [1:0] {
      IMM_NONE,
      IMM_SIGN,
      IMM_ZERO,
      IMM_UPPER
   } imm_kind_t;

   typedef struct packed {
      logic        valid;
      alu_op_t     alu_op;
      word_t       rdat1;
      word_t       rdat2;
      logic [15:0] imm16;
      imm_kind_t   imm_kind;
      regbits_t    dest;
      logic        regwrite;
      logic        dmemREN;
      logic        dmemWEN;
      logic        halt;
   } dec_ex_t;

   typedef struct packed {
      logic     valid;
      word_t    aluResult;
      word_t    rdat2;
      regbits_t dest;
      logic     regwrite;
      logic     dmemREN;
      logic     dmemWEN;
      logic     halt;
   } ex_mem_t;

   typedef struct packed {
      logic     wen;
      regbits_t wsel;
      word_t    data;
   } wb_t;

endpackage

`default_nettype wire
